// ==== dv/strm_stimulus.txt ====
# one job per line, all values hex
# base stride length first_word last_word
00000100 00000004 0010 B0ABA2A5 1C170E01
00000201 00000004 0008 B9B0ABA2 457C776E
00000302 00000006 000A 86B9B0AB 38332A2D
00000403 00000005 000C 8F86B9B0 0E013833
00000040 00000011 0014 706B6265 0F063930
00000500 00000004 0000 00000000 00000000
000007FE 00000008 0018 A2A55C57 AAADA45F
00001001 00000003 0005 B9B0ABA2 D5CCC7FE
00002003 00000000 0001 8F86B9B0 8F86B9B0

// ==== dv/strm_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// strm_tb
// testbench for the load streamer with register writes, an in-order
// memory with random latency and stream checks against a byte model
// and a job file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module strm_tb import strm_pkg::*; ();

  localparam int unsigned RESP_DEPTH = 4;

  logic clk_i, rst_ni, cfg_we_i, mem_req_o, mem_gnt_i, mem_rvalid_i;
  logic out_valid_o, out_ready_i;
  cfg_addr_t cfg_addr_i;
  logic [31:0] cfg_wdata_i, cfg_rdata_o;
  addr_t mem_addr_o;
  mem_data_t mem_rdata_i;
  stream_data_t out_data_o;

  logic [31:0] q_base[$], q_stride[$], q_len[$], q_first[$], q_last[$]; // job table
  addr_t       pend_addr[$];  // outstanding requests, in order
  int unsigned pend_due[$];   // cycle at which each response may return
  logic [31:0] rng = 32'd21;
  logic [31:0] job_base, job_stride, job_first, job_last, held_data;
  int unsigned job_len, word_cnt, done_cnt, issued, delivered, errors, cyc, stall_left;
  int unsigned total_words, wd_cycles;
  logic        wd_armed, stalled;

  strm_top #(.RESP_DEPTH(RESP_DEPTH), .CNT_W(16)) i_dut (.*);

  always #20 clk_i = ~clk_i; // 40 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory content is the low byte of 7*a xor a5
  function automatic logic [7:0] model_byte(input logic [31:0] a);
    logic [7:0] p;
    p = a[7:0] * 8'd7;
    return p ^ 8'hA5;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] x); // little endian
    return {model_byte(x + 32'd3), model_byte(x + 32'd2), model_byte(x + 32'd1), model_byte(x)};
  endfunction

  function automatic mem_data_t mem_line(input addr_t a);
    mem_data_t d;
    for (int i = 0; i < 8; i++) d[8*i +: 8] = model_byte(a + 32'(i));
    return d;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic cfg_write(input cfg_addr_t a, input logic [31:0] d);
    @(posedge clk_i);
    #2;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = a;
    cfg_wdata_i = d;
    @(posedge clk_i);
    #2;
    cfg_we_i = 1'b0;
  endtask

  task automatic cfg_read(input cfg_addr_t a, output logic [31:0] d);
    @(posedge clk_i);
    #2;
    cfg_addr_i = a;
    @(negedge clk_i); // rdata is combinational
    d = cfg_rdata_o;
  endtask

  // memory responses, grant and ready, driven just after the edge
  always @(posedge clk_i) begin
    #2;
    cyc++;
    if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = mem_line(pend_addr.pop_front());
      void'(pend_due.pop_front()); // drop head entry
    end else begin
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
    end
    rng       = xorshift(rng);
    mem_gnt_i = (rng[1:0] != 2'b00); // stall about one in four
    if (stall_left > 0) begin
      stall_left--;
      out_ready_i = 1'b0;
    end else if (rng[6:4] == 3'd0) begin
      stall_left  = 4 + int'(rng[12:8]); // long back-pressure stretch
      out_ready_i = 1'b0;
    end else out_ready_i = rng[9] | rng[10];
  end

  // sample mid cycle where values are stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (mem_req_o && mem_gnt_i) begin
        rng = xorshift(rng);
        pend_addr.push_back(mem_addr_o);
        pend_due.push_back(cyc + 1 + (rng % 32'd6)); // latency 1..6
        check("mem_addr_o[1:0]", {30'b0, mem_addr_o[1:0]}, 32'd0);
        issued++;
      end
      if (stalled) begin
        check("out_valid_o held", {31'b0, out_valid_o}, 32'd1);
        check("out_data_o held", out_data_o, held_data);
      end
      stalled   = out_valid_o & ~out_ready_i;
      held_data = out_data_o;
      if (out_valid_o && out_ready_i) begin
        if (word_cnt >= job_len) begin
          $display("extra output word %h after %0d words at %0t", out_data_o, job_len, $time);
          errors++;
        end else begin
          check("out_data_o", out_data_o, word_at(job_base + word_cnt * job_stride));
          if (word_cnt == 0) check("first word vs file", out_data_o, job_first);
          if (word_cnt == job_len - 1) check("last word vs file", out_data_o, job_last);
        end
        word_cnt++;
        delivered++;
      end
      if (issued - delivered > RESP_DEPTH) check("outstanding requests", issued - delivered,
                                                 RESP_DEPTH); // credit rule
      if (i_dut.done) done_cnt++;
    end
  end

  task automatic run_job(input int j);
    logic [31:0] rd;
    job_base   = q_base[j];
    job_stride = q_stride[j];
    job_len    = q_len[j];
    job_first  = q_first[j];
    job_last   = q_last[j];
    word_cnt   = 0;
    done_cnt   = 0;
    cfg_write(REG_BASE, job_base);
    cfg_write(REG_STRIDE, job_stride);
    cfg_write(REG_LENGTH, job_len);
    cfg_write(REG_CTRL, 32'd1);
    cfg_read(REG_CTRL, rd);
    check("busy after start", rd & 32'd1, 32'd1);
    if (job_len >= 8) begin // second start mid job is dropped
      while (word_cnt < job_len / 2) @(negedge clk_i);
      cfg_write(REG_CTRL, 32'd1);
    end
    while (done_cnt == 0) @(negedge clk_i);
    repeat (10) @(posedge clk_i);
    check("word count", word_cnt, job_len);
    check("done pulses", done_cnt, 32'd1);
    cfg_read(REG_CTRL, rd);
    check("ctrl status after done", rd & 32'd3, 32'd2); // idle with done_seen set
    cfg_write(REG_CTRL, 32'd0);                         // clears done_seen
    cfg_read(REG_CTRL, rd);
    check("done_seen after clear", rd & 32'd2, 32'd0);
  endtask

  initial begin
    string line;
    int fd;
    logic [31:0] b, s, l, f, la;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = REG_BASE;
    cfg_wdata_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    out_ready_i = 1'b0;
    job_len = 0;
    word_cnt = 0;
    done_cnt = 0;
    issued = 0;
    delivered = 0;
    errors = 0;
    cyc = 0;
    stall_left = 0;
    total_words = 0;
    wd_armed = 1'b0;
    stalled = 1'b0;
    fd = $fopen("dv/strm_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the job file dv/strm_stimulus.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%h %h %h %h %h",
                                                         b, s, l, f, la) == 5) begin
          q_base.push_back(b);
          q_stride.push_back(s);
          q_len.push_back(l);
          q_first.push_back(f);
          q_last.push_back(la);
          total_words += l;
        end
      end
      $fclose(fd);
    end
    wd_cycles = total_words * 40 + 2000;
    wd_armed  = 1'b1;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    foreach (q_base[j]) run_job(j);
    $display("%0d errors over %0d jobs and %0d words", errors, q_base.size(), delivered);
    if (errors == 0) $display("TESTS PASSED");
    else $display("TESTS FAILED");
    $finish;
  end

  // bounded by the total word count of the job file
  initial begin
    wait (wd_armed);
    repeat (wd_cycles) @(posedge clk_i);
    $display("timeout: %0d of %0d words arrived within %0d cycles",
             delivered, total_words, wd_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the load streamer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal -f strm.f --top-module strm_tb \
    -Mdir obj_dir -o strm_sim && ./obj_dir/strm_sim; } > sim.log 2>&1 \
  || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

// ==== source/strm_addrgen.sv ====
////////////////////////////////////////////////////////////////////////////
// strm_addrgen
// strided address generator: offers base + k*stride for k = 0..length-1
// and flags when the whole pattern has been accepted
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module strm_addrgen import strm_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  input  addr_t base_i,
  input  addr_t stride_i,
  input  len_t  length_i,
  output logic  addr_valid_o,
  output addr_t addr_o,
  input  logic  addr_ready_i,
  output logic  exhausted_o
);

  logic  active_q;    // addresses still to offer
  logic  exhausted_q;
  addr_t addr_q;      // running byte address
  addr_t stride_q;
  len_t  idx_q;       // index of the offered address
  len_t  len_q;
  logic  accept;
  logic  last;

  assign accept = active_q & addr_ready_i;
  assign last   = (idx_q == len_q - len_t'(1)); // final address of the job

  assign addr_valid_o = active_q;
  assign addr_o       = addr_q;
  assign exhausted_o  = exhausted_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      exhausted_q <= 1'b1; // nothing pending out of reset
    end else if (start_i) begin
      active_q    <= (length_i != '0);
      exhausted_q <= (length_i == '0); // empty job is done at once
    end else if (accept && last) begin
      active_q    <= 1'b0;
      exhausted_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
      len_q    <= length_i;
      idx_q    <= '0;
    end else if (accept) begin
      addr_q <= addr_q + stride_q; // next element
      idx_q  <= idx_q + len_t'(1);
    end
  end

endmodule

// ==== source/strm_cfg_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// strm_cfg_regs
// job configuration registers and status readback for the source,
// generates the start pulse while the source is ready
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module strm_cfg_regs import strm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cfg_we_i,
  input  cfg_addr_t   cfg_addr_i,
  input  logic [31:0] cfg_wdata_i,
  output logic [31:0] cfg_rdata_o,
  output addr_t       base_o,
  output addr_t       stride_o,
  output len_t        length_o,
  output logic        start_o,
  input  logic        ready_start_i,
  input  logic        busy_i,
  input  logic        done_i
);

  addr_t base_q;
  addr_t stride_q;
  len_t  length_q;
  logic  start_q;
  logic  done_seen_q; // sticky until next ctrl write
  logic  ctrl_wr;

  assign ctrl_wr = cfg_we_i & (cfg_addr_i == REG_CTRL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q      <= '0;
      stride_q    <= '0;
      length_q    <= '0;
      start_q     <= 1'b0;
      done_seen_q <= 1'b0;
    end else begin
      if (cfg_we_i && cfg_addr_i == REG_BASE)   base_q   <= cfg_wdata_i;
      if (cfg_we_i && cfg_addr_i == REG_STRIDE) stride_q <= cfg_wdata_i;
      if (cfg_we_i && cfg_addr_i == REG_LENGTH) length_q <= cfg_wdata_i[15:0];
      // start dropped if source still busy
      start_q <= ctrl_wr & cfg_wdata_i[CTRL_START_BIT] & ready_start_i;
      if (done_i)       done_seen_q <= 1'b1; // set wins over clear
      else if (ctrl_wr) done_seen_q <= 1'b0;
    end
  end

  // readback mux
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      REG_BASE:   cfg_rdata_o = base_q;
      REG_STRIDE: cfg_rdata_o = stride_q;
      REG_LENGTH: cfg_rdata_o = {16'b0, length_q};
      default: begin // REG_CTRL status
        cfg_rdata_o[CTRL_BUSY_BIT] = busy_i;
        cfg_rdata_o[CTRL_DONE_BIT] = done_seen_q;
      end
    endcase
  end

  assign base_o   = base_q;
  assign stride_o = stride_q;
  assign length_o = length_q;
  assign start_o  = start_q;

endmodule

// ==== source/strm_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// strm_fifo
// synchronous circular-buffer FIFO, payload type set by parameter,
// with full and empty flags and a synchronous clear
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module strm_fifo #(
  parameter type         item_t = logic [31:0],
  parameter int unsigned DEPTH  = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  push_valid_i,
  input  item_t push_data_i,
  input  logic  pop_ready_i,
  output logic  pop_valid_o,
  output item_t pop_data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned OCC_W = $clog2(DEPTH + 1);

  item_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [OCC_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign full_o      = (count_q == OCC_W'(DEPTH));
  assign empty_o     = (count_q == '0);
  assign pop_valid_o = ~empty_o;
  assign pop_data_o  = mem_q[rd_ptr_q]; // head of queue

  assign push = push_valid_i & ~full_o; // qualified handshakes
  assign pop  = pop_ready_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + OCC_W'(push) - OCC_W'(pop);
    end
  end

  // storage, no reset
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  // upstream must respect full, nothing may be dropped
  a_no_push_when_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_valid_i && full_o))
    else $error("strm_fifo: push while full");

endmodule

// ==== source/strm_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// strm_pkg
// shared widths, types, FSM states and register map of the load streamer
////////////////////////////////////////////////////////////////////////////

package strm_pkg;

  // data path widths
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned LEN_W    = 16;
  localparam int unsigned STREAM_W = 32;
  localparam int unsigned MEM_W    = STREAM_W + 32; // extra word for unaligned reads

  typedef logic [ADDR_W-1:0]   addr_t;        // byte address
  typedef logic [LEN_W-1:0]    len_t;         // words per job
  typedef logic [STREAM_W-1:0] stream_data_t;
  typedef logic [MEM_W-1:0]    mem_data_t;
  typedef logic [1:0]          offset_t;      // byte offset inside aligned word

  // job sequencing
  typedef enum logic [1:0] {
    STRM_IDLE     = 2'd0,
    STRM_WORKING  = 2'd1, // requests still being issued
    STRM_DRAINING = 2'd2  // waiting for the last words to leave
  } streamer_state_t;

  // configuration register map
  typedef logic [1:0] cfg_addr_t;

  localparam cfg_addr_t REG_BASE   = 2'd0;
  localparam cfg_addr_t REG_STRIDE = 2'd1;
  localparam cfg_addr_t REG_LENGTH = 2'd2;
  localparam cfg_addr_t REG_CTRL   = 2'd3; // wr bit0 start, rd {done_seen, busy}

  // status bit positions in REG_CTRL
  localparam int unsigned CTRL_START_BIT = 0;
  localparam int unsigned CTRL_BUSY_BIT  = 0;
  localparam int unsigned CTRL_DONE_BIT  = 1;

endpackage

// ==== source/strm_source.sv ====
////////////////////////////////////////////////////////////////////////////
// strm_source
// load source streamer: issues word-aligned reads with credit flow
// control, realigns the 64-bit responses to the requested byte offset
// and emits them as a valid/ready stream, ends the job after the last
// word has left
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module strm_source import strm_pkg::*; #(
  parameter int unsigned RESP_DEPTH = 4,
  parameter int unsigned CNT_W      = 16
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  addr_t        base_i,
  input  addr_t        stride_i,
  input  len_t         length_i,
  output logic         ready_start_o,
  output logic         busy_o,
  output logic         done_o,
  output logic         mem_req_o,
  output addr_t        mem_addr_o,
  input  logic         mem_gnt_i,
  input  logic         mem_rvalid_i,
  input  mem_data_t    mem_rdata_i,
  output logic         out_valid_o,
  output stream_data_t out_data_o,
  input  logic         out_ready_i
);

  localparam int unsigned CRED_W = $clog2(RESP_DEPTH + 1);

  streamer_state_t  state_q, state_d;
  logic             job_start;   // start taken in idle
  logic             ag_valid;
  addr_t            ag_addr;
  logic             ag_exhausted;
  logic             req_accept;
  logic [CRED_W-1:0] credit_q;   // free response FIFO slots
  logic             out_fire;
  logic [CNT_W-1:0] out_cnt_q;
  len_t             job_len_q;
  logic             cnt_reached;
  offset_t          off_head;
  logic             off_empty;
  logic             off_full;
  stream_data_t     rdata_aligned;
  logic             resp_full;

  assign job_start     = start_i & (state_q == STRM_IDLE);
  assign ready_start_o = (state_q == STRM_IDLE);
  assign busy_o        = (state_q != STRM_IDLE);

  strm_addrgen i_addrgen (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .start_i      ( job_start    ),
    .base_i       ( base_i       ),
    .stride_i     ( stride_i     ),
    .length_i     ( length_i     ),
    .addr_valid_o ( ag_valid     ),
    .addr_o       ( ag_addr      ),
    .addr_ready_i ( req_accept   ),
    .exhausted_o  ( ag_exhausted )
  );

  // request only while holding a credit
  assign mem_req_o  = (state_q == STRM_WORKING) & ag_valid & (credit_q != '0);
  assign mem_addr_o = {ag_addr[31:2], 2'b00};
  assign req_accept = mem_req_o & mem_gnt_i;

  // low address bits of every outstanding request, in order
  strm_fifo #(
    .item_t ( offset_t   ),
    .DEPTH  ( RESP_DEPTH )
  ) i_offset_fifo (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( job_start    ),
    .push_valid_i ( req_accept   ),
    .push_data_i  ( ag_addr[1:0] ),
    .pop_ready_i  ( mem_rvalid_i ),
    .pop_valid_o  (              ),
    .pop_data_o   ( off_head     ),
    .full_o       ( off_full     ),
    .empty_o      ( off_empty    )
  );

  // little endian bytes off..off+3 of the wide word
  assign rdata_aligned = mem_rdata_i[{off_head, 3'b000} +: 32];

  strm_fifo #(
    .item_t ( stream_data_t ),
    .DEPTH  ( RESP_DEPTH    )
  ) i_resp_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( job_start     ),
    .push_valid_i ( mem_rvalid_i  ),
    .push_data_i  ( rdata_aligned ),
    .pop_ready_i  ( out_ready_i   ),
    .pop_valid_o  ( out_valid_o   ),
    .pop_data_o   ( out_data_o    ),
    .full_o       ( resp_full     ),
    .empty_o      (               )
  );

  assign out_fire = out_valid_o & out_ready_i;

  // spend on grant, return when a word leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) credit_q <= CRED_W'(RESP_DEPTH);
    else         credit_q <= credit_q - CRED_W'(req_accept) + CRED_W'(out_fire);
  end

  // delivered words of the current job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)        out_cnt_q <= '0;
    else if (job_start) out_cnt_q <= '0;
    else if (out_fire)  out_cnt_q <= out_cnt_q + 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (job_start) job_len_q <= length_i;
  end

  assign cnt_reached = (out_cnt_q == CNT_W'(job_len_q));

  always_comb begin
    state_d = state_q;
    done_o  = 1'b0;
    case (state_q)
      STRM_IDLE:    if (start_i) state_d = STRM_WORKING;
      STRM_WORKING: if (ag_exhausted) state_d = STRM_DRAINING; // all requests out
      STRM_DRAINING: begin
        if (ag_exhausted && cnt_reached) begin
          state_d = STRM_IDLE;
          done_o  = 1'b1;
        end
      end
      default: state_d = STRM_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= STRM_IDLE;
    else         state_q <= state_d;
  end

  // every response needs a matching outstanding request
  a_rvalid_has_offset : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mem_rvalid_i && off_empty))
    else $error("strm_source: response without outstanding request");

  // credits plus occupied slots never exceed the FIFO size
  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (credit_q <= CRED_W'(RESP_DEPTH)) &&
    !((resp_full || off_full) && credit_q != '0))
    else $error("strm_source: credit count out of range");

endmodule

// ==== source/strm_top.sv ====
////////////////////////////////////////////////////////////////////////////
// strm_top
// load streamer top level: configuration registers plus source
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module strm_top import strm_pkg::*; #(
  parameter int unsigned RESP_DEPTH = 4,
  parameter int unsigned CNT_W      = 16
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         cfg_we_i,
  input  cfg_addr_t    cfg_addr_i,
  input  logic [31:0]  cfg_wdata_i,
  output logic [31:0]  cfg_rdata_o,
  output logic         mem_req_o,
  output addr_t        mem_addr_o,
  input  logic         mem_gnt_i,
  input  logic         mem_rvalid_i,
  input  mem_data_t    mem_rdata_i,
  output logic         out_valid_o,
  output stream_data_t out_data_o,
  input  logic         out_ready_i
);

  addr_t base;
  addr_t stride;
  len_t  length;
  logic  start;        // one-cycle pulse
  logic  ready_start;
  logic  busy;
  logic  done;

  strm_cfg_regs i_cfg_regs (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .cfg_we_i      ( cfg_we_i    ),
    .cfg_addr_i    ( cfg_addr_i  ),
    .cfg_wdata_i   ( cfg_wdata_i ),
    .cfg_rdata_o   ( cfg_rdata_o ),
    .base_o        ( base        ),
    .stride_o      ( stride      ),
    .length_o      ( length      ),
    .start_o       ( start       ),
    .ready_start_i ( ready_start ),
    .busy_i        ( busy        ),
    .done_i        ( done        )
  );

  strm_source #(
    .RESP_DEPTH ( RESP_DEPTH ),
    .CNT_W      ( CNT_W      )
  ) i_source (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .start_i       ( start        ),
    .base_i        ( base         ),
    .stride_i      ( stride       ),
    .length_i      ( length       ),
    .ready_start_o ( ready_start  ),
    .busy_o        ( busy         ),
    .done_o        ( done         ),
    .mem_req_o     ( mem_req_o    ),
    .mem_addr_o    ( mem_addr_o   ),
    .mem_gnt_i     ( mem_gnt_i    ),
    .mem_rvalid_i  ( mem_rvalid_i ),
    .mem_rdata_i   ( mem_rdata_i  ),
    .out_valid_o   ( out_valid_o  ),
    .out_data_o    ( out_data_o   ),
    .out_ready_i   ( out_ready_i  )
  );

endmodule

// ==== strm.f ====
source/strm_pkg.sv
source/strm_fifo.sv
source/strm_addrgen.sv
source/strm_cfg_regs.sv
source/strm_source.sv
source/strm_top.sv
dv/strm_tb.sv
